// File: verilog/armExecPkg.sv
package armExecPkg;

	// Datapath and bus widths
	localparam int dataW = 32;
	localparam int addrW = 7;        // Byte address of the AXI4-Lite register window
	localparam int regCnt = 16;      // R0..R15, R15 is an ordinary register here

	// Address map of the register block
	localparam logic [addrW-1:0] regBase = 7'h00;     // R0..R15 at 4-byte steps
	localparam logic [addrW-1:0] cpsrAddr = 7'h40;    // NZCV in bits 31:28
	localparam logic [addrW-1:0] instrAddr = 7'h44;   // Write starts execution
	localparam logic [addrW-1:0] statusAddr = 7'h48;  // Bit 0 is busy

	// AXI response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Data-processing opcodes, instr[24:21]
	typedef enum logic [3:0]
	{
		AND = 4'h0,
		EOR,
		SUB,
		RSB,
		ADD,
		ADC,
		SBC,
		RSC,
		TST,
		TEQ,
		CMP,
		CMN,
		ORR,
		MOV,
		BIC,
		MVN
	} aluOpE;

	// Shift types, instr[6:5]
	typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shiftTypeE;

	// Execute sequencer states
	typedef enum logic [1:0] {idle, operand, writeBack} execStateE;

endpackage

// File: verilog/execIf.sv
`timescale 1ns/10ps

interface execIf;

	logic start;                               // One cycle after an accepted instruction write
	logic [armExecPkg::dataW-1:0] instr;
	logic [3:0] rnAddr;
	logic [3:0] rmAddr;
	logic [3:0] rsAddr;
	logic [armExecPkg::dataW-1:0] rnVal;
	logic [armExecPkg::dataW-1:0] rmVal;
	logic [armExecPkg::dataW-1:0] rsVal;
	logic [3:0] cpsr;                          // N Z C V
	logic busy;
	logic wrEn;
	logic [3:0] wrAddr;
	logic [armExecPkg::dataW-1:0] wrData;
	logic flagsWe;
	logic [3:0] flagsNew;

	modport regs (output start, instr, rnVal, rmVal, rsVal, cpsr,
		input rnAddr, rmAddr, rsAddr, busy, wrEn, wrAddr, wrData, flagsWe, flagsNew);

	modport exec (input start, instr, rnVal, rmVal, rsVal, cpsr,
		output rnAddr, rmAddr, rsAddr, busy, wrEn, wrAddr, wrData, flagsWe, flagsNew);

endinterface

// File: verilog/axiLiteRegs.sv
`timescale 1ns/10ps

module axiLiteRegs (
	input logic clk,
	input logic rstN,
	input logic [armExecPkg::addrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [armExecPkg::dataW-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [armExecPkg::addrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [armExecPkg::dataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	execIf.regs ex
);

	logic [armExecPkg::dataW-1:0] regFile [armExecPkg::regCnt];
	logic [3:0] cpsr;
	logic [armExecPkg::dataW-1:0] instr;
	logic wrAccept;
	logic wrIsReg;
	logic wrIsCpsr;
	logic wrIsInstr;
	logic rdIsReg;
	logic [3:0] rdIdx;
	logic [armExecPkg::dataW-1:0] rdNext;

	function automatic logic [armExecPkg::dataW-1:0] mergeBytes(
		input logic [armExecPkg::dataW-1:0] oldVal,
		input logic [armExecPkg::dataW-1:0] newVal,
		input logic [3:0] strb
	);
		logic [armExecPkg::dataW-1:0] merged;
		merged = oldVal;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				merged[8*i +: 8] = newVal[8*i +: 8];
		end
		return merged;
	endfunction

	assign wrAccept = awvalid && awready && wvalid && wready;
	assign wrIsReg = (awaddr[armExecPkg::addrW-1:6] == armExecPkg::regBase[armExecPkg::addrW-1:6]);
	assign wrIsCpsr = (awaddr[armExecPkg::addrW-1:2] == armExecPkg::cpsrAddr[armExecPkg::addrW-1:2]);
	assign wrIsInstr = (awaddr[armExecPkg::addrW-1:2] == armExecPkg::instrAddr[armExecPkg::addrW-1:2]);

	// Operand reads for the execute unit
	assign ex.rnVal = regFile[ex.rnAddr];
	assign ex.rmVal = regFile[ex.rmAddr];
	assign ex.rsVal = regFile[ex.rsAddr];
	assign ex.cpsr = cpsr;
	assign ex.instr = instr;

	// Write channels, register file and flags
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= armExecPkg::respOkay;
			ex.start <= 1'b0;
			cpsr <= 4'h0;
			instr <= '0;
			for (int i = 0; i < armExecPkg::regCnt; i++)
				regFile[i] <= '0;
		end
		else
		begin
			// Both readies pulse together once address and data are waiting
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			ex.start <= wrAccept && wrIsInstr && !ex.busy;

			if (ex.wrEn)
				regFile[ex.wrAddr] <= ex.wrData;  // Rd commit from writeBack
			if (ex.flagsWe)
				cpsr <= ex.flagsNew;

			if (wrAccept)
			begin
				bvalid <= 1'b1;
				bresp <= ex.busy ? armExecPkg::respSlvErr : armExecPkg::respOkay;
				if (!ex.busy)
				begin
					if (wrIsReg)
						regFile[awaddr[5:2]] <= mergeBytes(regFile[awaddr[5:2]], wdata, wstrb);
					else if (wrIsCpsr && wstrb[3])
						cpsr <= wdata[31:28];
					else if (wrIsInstr)
						instr <= mergeBytes(instr, wdata, wstrb);
				end
			end
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// Read decode, forwards a commit that lands on the same edge
	assign rdIsReg = (araddr[armExecPkg::addrW-1:6] == armExecPkg::regBase[armExecPkg::addrW-1:6]);
	assign rdIdx = araddr[5:2];

	always_comb
	begin
		rdNext = '0;
		if (rdIsReg)
			rdNext = (ex.wrEn && ex.wrAddr == rdIdx) ? ex.wrData : regFile[rdIdx];
		else if (araddr[armExecPkg::addrW-1:2] == armExecPkg::cpsrAddr[armExecPkg::addrW-1:2])
			rdNext = {(ex.flagsWe ? ex.flagsNew : cpsr), 28'h0};
		else if (araddr[armExecPkg::addrW-1:2] == armExecPkg::instrAddr[armExecPkg::addrW-1:2])
			rdNext = instr;
		else if (araddr[armExecPkg::addrW-1:2] == armExecPkg::statusAddr[armExecPkg::addrW-1:2])
			rdNext = {31'h0, ex.busy};
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !arready && !rvalid;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (arvalid && arready)
			rdata <= rdNext;
	end

	assign rresp = armExecPkg::respOkay;

	bvalidHold: assert property (@(posedge clk) disable iff (!rstN)
		bvalid && !bready |=> bvalid && $stable(bresp));

	// Each start is a single pulse that the execute unit turns into busy
	startIdle: assert property (@(posedge clk) disable iff (!rstN)
		ex.start |=> ex.busy && !ex.start);

endmodule

// File: verilog/shifterOperand.sv
`timescale 1ns/10ps

module shifterOperand (
	input logic [armExecPkg::dataW-1:0] instr,
	input logic [armExecPkg::dataW-1:0] rmVal,
	input logic [armExecPkg::dataW-1:0] rsVal,
	input logic carryIn,
	output logic [armExecPkg::dataW-1:0] operand,
	output logic carryOut
);

	armExecPkg::shiftTypeE shType;
	logic [4:0] rotImm;
	logic [2*armExecPkg::dataW-1:0] immRot;
	logic [7:0] amt;                           // Effective shift amount, 0..255
	logic rrx;
	logic [armExecPkg::dataW:0] lslExt;        // Carry in bit 32
	logic [armExecPkg::dataW:0] lsrExt;        // Carry in bit 0
	logic signed [armExecPkg::dataW:0] asrIn;
	logic signed [armExecPkg::dataW:0] asrExt;
	logic [2*armExecPkg::dataW-1:0] rorExt;

	assign shType = armExecPkg::shiftTypeE'(instr[6:5]);

	// 8-bit immediate rotated right by twice the rotate field
	assign rotImm = {instr[11:8], 1'b0};
	assign immRot = {24'h0, instr[7:0], 24'h0, instr[7:0]} >> rotImm;

	// Zero-amount rules for the immediate shift form
	always_comb
	begin
		rrx = 1'b0;
		if (instr[4])
			amt = rsVal[7:0];
		else
		begin
			amt = {3'b000, instr[11:7]};
			if (instr[11:7] == 5'd0)
			begin
				case (shType)
					armExecPkg::LSR, armExecPkg::ASR: amt = 8'd32;
					armExecPkg::ROR: rrx = 1'b1;
					default: amt = 8'd0;         // LSL #0 passes Rm
				endcase
			end
		end
	end

	// Shifts extended by one bit so the last bit shifted out lands in the carry slot
	assign lslExt = {1'b0, rmVal} << amt;
	assign lsrExt = {rmVal, 1'b0} >> amt;
	assign asrIn = {rmVal, 1'b0};
	assign asrExt = asrIn >>> amt;
	assign rorExt = {rmVal, rmVal} >> amt[4:0];  // Amount taken modulo 32

	always_comb
	begin
		if (instr[25])
		begin
			operand = immRot[armExecPkg::dataW-1:0];
			carryOut = (instr[11:8] != 4'd0) ? operand[31] : carryIn;
		end
		else if (rrx)
		begin
			operand = {carryIn, rmVal[31:1]};
			carryOut = rmVal[0];
		end
		else if (amt == 8'd0)
		begin
			operand = rmVal;
			carryOut = carryIn;
		end
		else
		begin
			case (shType)
				armExecPkg::LSL:
				begin
					operand = lslExt[armExecPkg::dataW-1:0];
					carryOut = lslExt[armExecPkg::dataW];
				end
				armExecPkg::LSR:
				begin
					operand = lsrExt[armExecPkg::dataW:1];
					carryOut = lsrExt[0];
				end
				armExecPkg::ASR:
				begin
					operand = asrExt[armExecPkg::dataW:1];
					carryOut = asrExt[0];
				end
				default:
				begin
					operand = rorExt[armExecPkg::dataW-1:0];
					carryOut = operand[31];      // Also right for multiples of 32
				end
			endcase
		end
	end

	always_comb
	begin
		if (!$isunknown({instr, rmVal, rsVal, carryIn}))
			operandKnown: assert final (!$isunknown({operand, carryOut}));
	end

endmodule

// File: verilog/aluCore.sv
`timescale 1ns/10ps

module aluCore (
	input armExecPkg::aluOpE op,
	input logic [armExecPkg::dataW-1:0] a,
	input logic [armExecPkg::dataW-1:0] b,
	input logic shCarry,
	input logic [3:0] flagsIn,
	output logic [armExecPkg::dataW-1:0] result,
	output logic writesRd,
	output logic [3:0] flagsOut
);

	logic [armExecPkg::dataW-1:0] addX;
	logic [armExecPkg::dataW-1:0] addY;
	logic addCin;
	logic isArith;
	logic [armExecPkg::dataW:0] sum;
	logic overflow;

	// One adder serves every arithmetic opcode, subtraction as X + ~Y + 1
	always_comb
	begin
		addX = a;
		addY = b;
		addCin = 1'b0;
		isArith = 1'b1;
		case (op)
			armExecPkg::SUB, armExecPkg::CMP:
			begin
				addY = ~b;
				addCin = 1'b1;
			end
			armExecPkg::RSB:
			begin
				addX = b;
				addY = ~a;
				addCin = 1'b1;
			end
			armExecPkg::ADD, armExecPkg::CMN: addCin = 1'b0;
			armExecPkg::ADC: addCin = flagsIn[1];
			armExecPkg::SBC:
			begin
				addY = ~b;
				addCin = flagsIn[1];
			end
			armExecPkg::RSC:
			begin
				addX = b;
				addY = ~a;
				addCin = flagsIn[1];
			end
			default: isArith = 1'b0;
		endcase
	end

	assign sum = {1'b0, addX} + {1'b0, addY} + {{armExecPkg::dataW{1'b0}}, addCin};
	assign overflow = (addX[31] == addY[31]) && (sum[31] != addX[31]);

	always_comb
	begin
		case (op)
			armExecPkg::AND, armExecPkg::TST: result = a & b;
			armExecPkg::EOR, armExecPkg::TEQ: result = a ^ b;
			armExecPkg::ORR: result = a | b;
			armExecPkg::MOV: result = b;
			armExecPkg::BIC: result = a & ~b;
			armExecPkg::MVN: result = ~b;
			default: result = sum[armExecPkg::dataW-1:0];
		endcase
	end

	assign writesRd = !(op inside {armExecPkg::TST, armExecPkg::TEQ, armExecPkg::CMP,
		armExecPkg::CMN});

	// Carry out of the adder is already the inverted borrow for subtractions
	assign flagsOut = {result[31], (result == '0), (isArith ? sum[armExecPkg::dataW] : shCarry),
		(isArith ? overflow : flagsIn[0])};

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/10ps

module execUnit (
	input logic clk,
	input logic rstN,
	execIf.exec ex
);

	armExecPkg::execStateE state;
	logic [armExecPkg::dataW-1:0] shOperand;
	logic shCarry;
	logic [armExecPkg::dataW-1:0] aluResult;
	logic aluWritesRd;
	logic [3:0] aluFlags;
	logic [armExecPkg::dataW-1:0] resultQ;
	logic writesRdQ;
	logic [3:0] flagsQ;

	// Operand register addresses straight from the instruction
	assign ex.rnAddr = ex.instr[19:16];
	assign ex.rmAddr = ex.instr[3:0];
	assign ex.rsAddr = ex.instr[11:8];

	shifterOperand shifterOperand_i (
		.instr(ex.instr),
		.rmVal(ex.rmVal),
		.rsVal(ex.rsVal),
		.carryIn(ex.cpsr[1]),
		.operand(shOperand),
		.carryOut(shCarry)
	);

	aluCore aluCore_i (
		.op(armExecPkg::aluOpE'(ex.instr[24:21])),
		.a(ex.rnVal),
		.b(shOperand),
		.shCarry(shCarry),
		.flagsIn(ex.cpsr),
		.result(aluResult),
		.writesRd(aluWritesRd),
		.flagsOut(aluFlags)
	);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= armExecPkg::idle;
			writesRdQ <= 1'b0;
		end
		else
		begin
			case (state)
				armExecPkg::idle:
					if (ex.start)
						state <= armExecPkg::operand;
				armExecPkg::operand:
				begin
					state <= armExecPkg::writeBack;
					writesRdQ <= aluWritesRd;
				end
				default: state <= armExecPkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == armExecPkg::operand)
		begin
			resultQ <= aluResult;
			flagsQ <= aluFlags;
		end
	end

	assign ex.busy = ex.start || (state != armExecPkg::idle);  // Held through the commit edge
	assign ex.wrEn = (state == armExecPkg::writeBack) && writesRdQ;
	assign ex.wrAddr = ex.instr[15:12];
	assign ex.wrData = resultQ;
	assign ex.flagsWe = (state == armExecPkg::writeBack) && ex.instr[20];  // S bit
	assign ex.flagsNew = flagsQ;

	// Commit two edges after start, with the instruction unchanged since the operand state
	commitAfterOperand: assert property (@(posedge clk) disable iff (!rstN)
		(ex.wrEn || ex.flagsWe) |-> $past(ex.start, 2) && $stable(ex.instr));

endmodule

// File: verilog/armExecTop.sv
`timescale 1ns/10ps

module armExecTop (
	input logic clk,
	input logic rstN,
	input logic [armExecPkg::addrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [armExecPkg::dataW-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [armExecPkg::addrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [armExecPkg::dataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	execIf execIf_i ();

	axiLiteRegs axiLiteRegs_i (
		.clk(clk),
		.rstN(rstN),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.ex(execIf_i.regs)
	);

	execUnit execUnit_i (
		.clk(clk),
		.rstN(rstN),
		.ex(execIf_i.exec)
	);

endmodule

// File: test/armExecChecker.sv
`timescale 1ns/10ps

module armExecChecker (
	input logic clk,
	input logic rstN,
	input logic [6:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [6:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	output int errCount
);

	logic [31:0] regs [16];
	logic [3:0] flags;
	logic [31:0] lastInstr;
	int busyCnt;                               // Edges left until the commit has passed
	logic [1:0] expResp;
	logic [31:0] expRead;
	logic [6:0] rAddr;

	// Returns {C, V, result} of x + y + cin
	function automatic logic [33:0] addOp(input logic [31:0] x, y, input logic cin);
		logic [32:0] t;
		t = {1'b0, x} + {1'b0, y} + {32'h0, cin};
		return {t[32], (x[31] == y[31]) && (t[31] != x[31]), t[31:0]};
	endfunction

	// Returns {C, V, result} of x - y - bw, C set when nothing is borrowed
	function automatic logic [33:0] subOp(input logic [31:0] x, y, input logic bw);
		logic [31:0] r;
		r = x - y - {31'h0, bw};
		return {({1'b0, x} >= {1'b0, y} + {32'h0, bw}), (x[31] != y[31]) && (r[31] != x[31]), r};
	endfunction

	function automatic void armRef(input logic [31:0] ins, rn, rm, rs, input logic [3:0] nzcv,
		output logic [31:0] res, output logic wr, output logic [3:0] fl);
		logic [31:0] b;
		logic sc;
		logic [33:0] cvr;
		int n;
		int k;
		sc = nzcv[1];
		n = ins[4] ? int'(rs[7:0]) : int'(ins[11:7]);
		if (ins[25])
		begin
			k = 2 * ins[11:8];
			b = {24'h0, ins[7:0]};
			b = (b >> k) | (b << (32 - k));
			if (k != 0)
				sc = b[31];
		end
		else if (!ins[4] && n == 0 && ins[6:5] == 2'd3)
		begin
			b = {nzcv[1], rm[31:1]};             // RRX
			sc = rm[0];
		end
		else
		begin
			if (!ins[4] && n == 0 && ins[6:5] != 2'd0)
				n = 32;
			b = rm;
			if (n != 0)
			begin
				case (ins[6:5])
					2'd0:
					begin
						b = (n < 32) ? rm << n : 32'h0;
						sc = (n <= 32) ? rm[32 - n] : 1'b0;
					end
					2'd1:
					begin
						b = (n < 32) ? rm >> n : 32'h0;
						sc = (n <= 32) ? rm[n - 1] : 1'b0;
					end
					2'd2:
					begin
						if (n < 32)
							b = $signed(rm) >>> n;
						else
							b = {32{rm[31]}};
						sc = rm[(n < 32) ? n - 1 : 31];
					end
					default:
					begin
						k = n % 32;
						if (k != 0)
							b = (rm >> k) | (rm << (32 - k));
						sc = rm[(k != 0) ? k - 1 : 31];
					end
				endcase
			end
		end
		cvr = {sc, nzcv[0], 32'h0};             // Logical ops keep V
		case (ins[24:21])
			4'd0, 4'd8: cvr[31:0] = rn & b;
			4'd1, 4'd9: cvr[31:0] = rn ^ b;
			4'd2, 4'd10: cvr = subOp(rn, b, 1'b0);
			4'd3: cvr = subOp(b, rn, 1'b0);
			4'd4, 4'd11: cvr = addOp(rn, b, 1'b0);
			4'd5: cvr = addOp(rn, b, nzcv[1]);
			4'd6: cvr = subOp(rn, b, !nzcv[1]);
			4'd7: cvr = subOp(b, rn, !nzcv[1]);
			4'd12: cvr[31:0] = rn | b;
			4'd13: cvr[31:0] = b;
			4'd14: cvr[31:0] = rn & ~b;
			default: cvr[31:0] = ~b;
		endcase
		res = cvr[31:0];
		wr = !(ins[24:21] inside {[4'd8:4'd11]});
		fl = ins[20] ? {res[31], res == 32'h0, cvr[33], cvr[32]} : nzcv;
	endfunction

	always @(posedge clk)
	begin
		logic busyNow;
		logic [31:0] res;
		logic wr;
		logic [3:0] fl;
		if (!rstN)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] = 32'h0;
			flags = 4'h0;
			lastInstr = 32'h0;
			busyCnt = 0;
			errCount = 0;
		end
		else
		begin
			busyNow = (busyCnt != 0);
			if (busyCnt != 0)
				busyCnt--;
			if (rvalid && rready && rdata !== expRead)
			begin
				$display("[FAIL] rdata addr 0x%02h got 0x%08h expected 0x%08h",
					rAddr, rdata, expRead);
				errCount++;
			end
			if (rvalid && rready && rresp !== 2'b00)
			begin
				$display("[FAIL] rresp got 0x%01h expected 0x0", rresp);
				errCount++;
			end
			if (bvalid && bready && bresp !== expResp)
			begin
				$display("[FAIL] bresp got 0x%01h expected 0x%01h", bresp, expResp);
				errCount++;
			end
			// Read data is taken from the state before this edge's write
			if (arvalid && arready)
			begin
				rAddr = araddr;
				if (!araddr[6])
					expRead = regs[araddr[5:2]];
				else if (araddr[5:2] == 4'h0)
					expRead = {flags, 28'h0};
				else if (araddr[5:2] == 4'h1)
					expRead = lastInstr;
				else if (araddr[5:2] == 4'h2)
					expRead = {31'h0, busyNow};
				else
					expRead = 32'h0;
			end
			if (awvalid && awready && wvalid && wready)
			begin
				expResp = busyNow ? 2'b10 : 2'b00;
				if (!busyNow)
				begin
					for (int i = 0; i < 4; i++)
					begin
						if (wstrb[i] && !awaddr[6])
							regs[awaddr[5:2]][8*i +: 8] = wdata[8*i +: 8];
						if (wstrb[i] && awaddr[6:2] == 5'h11)
							lastInstr[8*i +: 8] = wdata[8*i +: 8];
					end
					if (awaddr[6:2] == 5'h10 && wstrb[3])
						flags = wdata[31:28];
					if (awaddr[6:2] == 5'h11)
					begin
						armRef(lastInstr, regs[lastInstr[19:16]], regs[lastInstr[3:0]],
							regs[lastInstr[11:8]], flags, res, wr, fl);
						if (wr)
							regs[lastInstr[15:12]] = res;
						flags = fl;
						busyCnt = 3;
					end
				end
			end
		end
	end

endmodule

// File: test/armExecTb.sv
`timescale 1ns/10ps

module armExecTb;

	localparam logic [6:0] cpsrA = 7'h40;
	localparam logic [6:0] instrA = 7'h44;
	localparam logic [6:0] statusA = 7'h48;
	localparam int timeoutCycles = 100;

	logic clk;
	logic rstN;
	logic [6:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [6:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	int errCount;
	int tbErrors;
	int prevErrs;
	int testsOk;
	int testsBad;
	logic [31:0] seed;

	always #10 clk = ~clk;

	armExecTop armExecTop_i (.*);

	armExecChecker armExecChecker_i (.clk(clk), .rstN(rstN), .awaddr(awaddr), .awvalid(awvalid),
		.awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready), .araddr(araddr), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.errCount(errCount));

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic axiWrite(input logic [6:0] addr, input logic [31:0] data, output logic [1:0] resp);
		int n;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		resp = 2'b11;
		n = 0;
		@(negedge clk);
		while (!awready && n < timeoutCycles)
		begin
			@(negedge clk);
			n++;
		end
		@(negedge clk);                          // Address and data taken on the edge before
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid && n < timeoutCycles)
		begin
			@(negedge clk);
			n++;
		end
		if (bvalid)
			resp = bresp;
		else
		begin
			$display("Write to 0x%02h timed out waiting for the handshake", addr);
			tbErrors++;
		end
	endtask

	task automatic axiRead(input logic [6:0] addr, output logic [31:0] data);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		data = 32'h0;
		n = 0;
		@(negedge clk);
		while (!arready && n < timeoutCycles)
		begin
			@(negedge clk);
			n++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < timeoutCycles)
		begin
			@(negedge clk);
			n++;
		end
		if (rvalid)
			data = rdata;
		else
		begin
			$display("Read of 0x%02h timed out waiting for read data", addr);
			tbErrors++;
		end
	endtask

	task automatic writeVal(input logic [6:0] addr, input logic [31:0] v);
		logic [1:0] resp;
		axiWrite(addr, v, resp);
	endtask

	// Polls the status word until busy clears
	task automatic waitIdle();
		logic [31:0] d;
		int n;
		n = 0;
		d = 32'h1;
		while (d[0] && n < timeoutCycles)
		begin
			axiRead(statusA, d);
			n++;
		end
		if (d[0])
		begin
			$display("Execute unit stayed busy");
			tbErrors++;
		end
	endtask

	task automatic runInstr(input logic [31:0] ins, input logic [3:0] rd);
		logic [31:0] d;
		writeVal(instrA, ins);
		waitIdle();
		axiRead({1'b0, rd, 2'b00}, d);
		axiRead(cpsrA, d);
	endtask

	task automatic endTest(input string name);
		repeat (2) @(negedge clk);               // Let the checker see the last response
		if (errCount + tbErrors == prevErrs)
		begin
			$display("test %s: ok", name);
			testsOk++;
		end
		else
		begin
			$display("test %s: %0d errors", name, errCount + tbErrors - prevErrs);
			testsBad++;
		end
		prevErrs = errCount + tbErrors;
	endtask

	initial
	begin
		logic [31:0] d;
		logic [31:0] r;
		logic [1:0] resp;
		logic [7:0] amts [6];
		logic [4:0] amt;
		amts = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd255};
		seed = 32'h3ae73ccb;
		clk = 1'b0;
		rstN = 1'b0;
		{awaddr, awvalid, wdata, wvalid, araddr, arvalid} = '0;
		wstrb = 4'hF;
		bready = 1'b1;
		rready = 1'b1;
		{tbErrors, prevErrs, testsOk, testsBad} = '0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		for (int i = 0; i < 16; i++)
			writeVal(7'(4 * i), nextRand());
		writeVal(cpsrA, nextRand());
		for (int i = 0; i < 16; i++)
			axiRead(7'(4 * i), d);
		axiRead(cpsrA, d);
		axiRead(statusA, d);
		endTest("register access");

		for (int s = 0; s < 2; s++)
			for (int rot = 0; rot < 16; rot++)
			begin
				r = nextRand();
				writeVal(cpsrA, nextRand());
				runInstr({4'hE, 3'b001, 4'hD, s[0], 4'h0, 4'h1, rot[3:0], r[7:0]}, 4'd1);
			end
		endTest("rotated immediate");

		for (int t = 0; t < 4; t++)
			for (int j = 0; j < 4; j++)
			begin
				r = nextRand();
				amt = (j == 0) ? 5'd0 : (j == 1) ? 5'd1 : (j == 2) ? 5'd31 : r[12:8];
				writeVal(7'h08, nextRand());
				writeVal(cpsrA, nextRand());
				runInstr({4'hE, 3'b000, 4'hD, 1'b1, 4'h0, 4'h3, amt, t[1:0], 1'b0, 4'h2}, 4'd3);
			end
		endTest("shift by immediate");

		for (int t = 0; t < 4; t++)
			for (int j = 0; j < 6; j++)
			begin
				r = nextRand();
				writeVal(7'h10, {r[31:8], amts[j]});
				writeVal(7'h08, nextRand());
				writeVal(cpsrA, nextRand());
				runInstr({4'hE, 3'b000, 4'hD, 1'b1, 4'h0, 4'h3, 4'h4, 1'b0, t[1:0], 1'b1, 4'h2}, 4'd3);
			end
		endTest("shift by register");

		for (int op = 0; op < 16; op++)
			for (int s = 0; s < 2; s++)
			begin
				writeVal(7'h14, nextRand());
				writeVal(7'h18, nextRand());
				writeVal(7'h1C, nextRand());
				writeVal(cpsrA, nextRand());
				r = nextRand();
				runInstr({4'hE, 3'b000, op[3:0], s[0], 4'h5, 4'h7, r[4:0], r[6:5], 1'b0, 4'h6}, 4'd7);
			end
		endTest("all opcodes");

		// Status read and register write land while the instruction is in flight
		writeVal(instrA, {4'hE, 3'b000, 4'h4, 1'b1, 4'h5, 4'h8, 8'h00, 4'h6});
		axiRead(statusA, d);
		waitIdle();
		axiRead(7'h20, d);
		writeVal(instrA, {4'hE, 3'b000, 4'hD, 1'b0, 4'h0, 4'h9, 8'h00, 4'h6});
		axiWrite(7'h04, 32'h5A5A_A5A5, resp);
		if (resp !== 2'b10)
		begin
			$display("[FAIL] bresp got 0x%01h expected 0x2", resp);
			tbErrors++;
		end
		waitIdle();
		axiRead(7'h04, d);
		axiRead(7'h24, d);
		endTest("busy handling");

		$display("tests ok %0d, failed %0d, errors %0d", testsOk, testsBad, errCount + tbErrors);
		if (testsBad == 0 && errCount + tbErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: armExecTop.f
verilog/armExecPkg.sv
verilog/execIf.sv
verilog/axiLiteRegs.sv
verilog/shifterOperand.sv
verilog/aluCore.sv
verilog/execUnit.sv
verilog/armExecTop.sv
test/armExecChecker.sv
test/armExecTb.sv

// File: Makefile
# Verilator build and run of the execute unit testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f armExecTop.f \
		--top-module armExecTb -Mdir obj_dir
	./obj_dir/VarmExecTb | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
